// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_top
FILELIST  ?= tb.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: hw/cycle_timer.sv
`timescale 1ns/1ns

module cycle_timer #(
   parameter logic [31:0] max_cycles_p = 32'd2000
) (
   input  logic clk,
   input  logic reset,
   input  logic running_i,
   output logic expired_o
);

   logic [31:0] count_q;

   // stops counting at the limit and holds there
   always_ff @(posedge clk) begin
      if (reset) begin
         count_q <= '0;
      end else if (running_i && count_q != max_cycles_p) begin
         count_q <= count_q + 32'd1;
      end
   end

   assign expired_o = (count_q == max_cycles_p);

endmodule

// File: hw/execute_unit.sv
`timescale 1ns/1ns

module execute_unit #(
   parameter rv_pkg::word_t result_addr_p = 32'h0000_0100
) (
   input  rv_pkg::word_t     pc_i,
   input  rv_pkg::word_t     instr_i,
   input  rv_pkg::word_t     rs1_data_i,
   input  rv_pkg::word_t     rs2_data_i,
   input  rv_pkg::word_t     load_data_i,
   input  rv_pkg::word_t     success_code_i,
   input  logic              wb_strobe_i,
   output rv_pkg::reg_idx_t  rs1_o,
   output rv_pkg::reg_idx_t  rs2_o,
   output rv_pkg::reg_idx_t  rd_o,
   output logic              rd_we_o,
   output rv_pkg::word_t     rd_data_o,
   output rv_pkg::mem_kind_t mem_kind_o,
   output rv_pkg::word_t     next_pc_o,
   output logic              end_hit_o,
   mem_cmd_if.command        data_cmd
);
   import rv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;
   word_t      alu_b;
   word_t      alu_res;
   word_t      mem_sum;
   word_t      mem_addr;
   logic       alu_ok;
   logic       writes_rd;
   logic       taken;
   mem_kind_t  kind;

   assign opcode = instr_i[6:0];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];
   assign rd_o   = instr_i[11:7];
   assign rs1_o  = instr_i[19:15];
   assign rs2_o  = instr_i[24:20];

   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
   assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
   assign imm_u = {instr_i[31:12], 12'b0};
   assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

   assign alu_b = (opcode == op_op) ? rs2_data_i : imm_i;

   always_comb begin
      alu_ok  = 1'b1;
      alu_res = '0;
      case (funct3)
         f3_add_sub: begin
            if (opcode == op_op && funct7 == f7_sub) begin
               alu_res = rs1_data_i - alu_b;
            end else begin
               alu_res = rs1_data_i + alu_b;
            end
         end
         f3_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(rs1_data_i) < $signed(alu_b)};
         f3_xor:  alu_res = rs1_data_i ^ alu_b;
         f3_or:   alu_res = rs1_data_i | alu_b;
         f3_and:  alu_res = rs1_data_i & alu_b;
         default: alu_ok = 1'b0;
      endcase
      // register ops only in base form or SUB
      if (opcode == op_op && !(funct7 == f7_base ||
                               (funct7 == f7_sub && funct3 == f3_add_sub))) begin
         alu_ok = 1'b0;
      end
      // immediate form is ADDI only
      if (opcode == op_op_imm && funct3 != f3_add_sub) begin
         alu_ok = 1'b0;
      end
   end

   always_comb begin
      writes_rd = 1'b0;
      rd_data_o = alu_res;
      kind      = mk_none;
      taken     = 1'b0;
      next_pc_o = pc_i + 32'd4;
      case (opcode)
         op_lui: begin
            writes_rd = 1'b1;
            rd_data_o = imm_u;
         end
         op_op_imm, op_op: writes_rd = alu_ok;
         op_branch: begin
            taken = (funct3 == f3_beq && rs1_data_i == rs2_data_i) ||
                    (funct3 == f3_bne && rs1_data_i != rs2_data_i);
            if (taken) begin
               next_pc_o = pc_i + imm_b;
            end
         end
         op_jal: begin
            writes_rd = 1'b1;
            rd_data_o = pc_i + 32'd4;
            next_pc_o = pc_i + imm_j;
         end
         op_load: begin
            if (funct3 == f3_word) begin
               kind      = mk_load;
               writes_rd = 1'b1;
               rd_data_o = load_data_i;
            end
         end
         op_store: begin
            if (funct3 == f3_word) begin
               kind = mk_store;
            end
         end
         // anything else falls through as a no-op
         default: writes_rd = 1'b0;
      endcase
   end

   // word access only, low address bits dropped
   assign mem_sum  = rs1_data_i + ((opcode == op_store) ? imm_s : imm_i);
   assign mem_addr = {mem_sum[xlen-1:2], 2'b00};

   assign data_cmd.addr  = mem_addr;
   assign data_cmd.we    = (kind == mk_store);
   assign data_cmd.be    = 4'b1111;
   assign data_cmd.wdata = rs2_data_i;

   assign mem_kind_o = kind;
   assign rd_we_o    = wb_strobe_i && writes_rd;
   assign end_hit_o  = (kind == mk_store) && (mem_addr == result_addr_p) &&
                       (rs2_data_i == success_code_i);

endmodule

// File: hw/mem_cmd_if.sv
`timescale 1ns/1ns

interface mem_cmd_if;
   logic          start;
   rv_pkg::word_t addr;
   logic          we;
   logic [3:0]    be;
   rv_pkg::word_t wdata;
   logic          done;
   rv_pkg::word_t rdata;

   // one side issues the whole command
   modport requester (output start, addr, we, be, wdata, input done, rdata);
   // command split between two owners
   modport starter (output start, input done, rdata);
   modport command (output addr, we, be, wdata);

   modport engine (input start, addr, we, be, wdata, output done, rdata);
endinterface

// File: hw/mem_master.sv
`timescale 1ns/1ns

module mem_master (
   input  logic          clk,
   input  logic          reset,
   mem_cmd_if.engine     cmd,
   output logic          req_o,
   output rv_pkg::word_t addr_o,
   output logic          we_o,
   output logic [3:0]    be_o,
   output rv_pkg::word_t wdata_o,
   input  logic          gnt_i,
   input  logic          rvalid_i,
   input  rv_pkg::word_t rdata_i
);

   typedef enum logic [1:0] {
      eng_idle,
      eng_req,
      eng_wait
   } eng_state_t;

   eng_state_t state_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= eng_idle;
      end else begin
         case (state_q)
            eng_idle: begin
               if (cmd.start) begin
                  state_q <= eng_req;
               end
            end
            eng_req: begin
               if (gnt_i) begin
                  state_q <= eng_wait;
               end
            end
            eng_wait: begin
               if (rvalid_i) begin
                  state_q <= eng_idle;
               end
            end
            default: state_q <= eng_idle;
         endcase
      end
   end

   // command stays stable on the port until the access ends
   always_ff @(posedge clk) begin
      if (state_q == eng_idle && cmd.start) begin
         addr_o  <= cmd.addr;
         we_o    <= cmd.we;
         be_o    <= cmd.be;
         wdata_o <= cmd.wdata;
      end
   end

   assign req_o     = (state_q == eng_req);
   assign cmd.done  = (state_q == eng_wait) && rvalid_i;
   assign cmd.rdata = rdata_i;

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ns

module reg_file (
   input  logic             clk,
   input  logic             reset,
   input  rv_pkg::reg_idx_t rs1_i,
   input  rv_pkg::reg_idx_t rs2_i,
   input  rv_pkg::reg_idx_t rd_i,
   input  logic             we_i,
   input  rv_pkg::word_t    wdata_i,
   output rv_pkg::word_t    rs1_data_o,
   output rv_pkg::word_t    rs2_data_o
);
   import rv_pkg::*;

   word_t regs_q [32];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs_q[i] <= '0;
         end
      end else if (we_i && rd_i != '0) begin
         regs_q[rd_i] <= wdata_i;
      end
   end

   // x0 reads as zero
   assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
   assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

// File: hw/run_fsm.sv
`timescale 1ns/1ns

module run_fsm #(
   parameter rv_pkg::word_t reset_pc_p = 32'h0000_0000
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              run_i,
   input  logic              end_hit_i,
   input  rv_pkg::mem_kind_t mem_kind_i,
   input  rv_pkg::word_t     next_pc_i,
   input  logic              expired_i,
   mem_cmd_if.requester      fetch_cmd,
   mem_cmd_if.starter        data_cmd,
   output rv_pkg::word_t     pc_o,
   output rv_pkg::word_t     instr_o,
   output rv_pkg::word_t     load_data_o,
   output logic              wb_strobe_o,
   output logic              running_o,
   output logic              finished_o,
   output logic              timeout_o
);
   import rv_pkg::*;

   run_state_t state_q;
   run_state_t state_d;
   word_t      pc_q;
   word_t      instr_q;
   word_t      load_q;
   logic       finished_q;
   logic       timeout_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (run_i) begin
               state_d = st_fetch;
            end
         end
         st_fetch: begin
            if (fetch_cmd.done) begin
               state_d = expired_i ? st_done : st_execute;
            end
         end
         st_execute: begin
            if (expired_i) begin
               state_d = st_done;
            end else if (mem_kind_i != mk_none) begin
               state_d = st_memory;
            end else begin
               state_d = st_writeback;
            end
         end
         st_memory: begin
            // an open access always runs to its rvalid first
            if (data_cmd.done) begin
               state_d = expired_i ? st_done : st_writeback;
            end
         end
         st_writeback: state_d = (end_hit_i || expired_i) ? st_done : st_fetch;
         st_done:      state_d = st_done;
         default:      state_d = st_idle;
      endcase
   end

   // requests go out on entry to fetch or memory
   assign fetch_cmd.start = (state_d == st_fetch) && (state_q != st_fetch);
   // in writeback the pc register is only updated at the edge
   assign fetch_cmd.addr  = (state_q == st_writeback) ? next_pc_i : pc_q;
   assign fetch_cmd.we    = 1'b0;
   assign fetch_cmd.be    = 4'b1111;
   assign fetch_cmd.wdata = '0;
   assign data_cmd.start  = (state_d == st_memory) && (state_q != st_memory);

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q    <= st_idle;
         pc_q       <= reset_pc_p;
         finished_q <= 1'b0;
         timeout_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         if (state_q == st_writeback) begin
            pc_q <= next_pc_i;
         end
         if (state_d == st_done && state_q != st_done) begin
            finished_q <= 1'b1;
            // success store wins over a coincident expiry
            timeout_q  <= !(state_q == st_writeback && end_hit_i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == st_fetch && fetch_cmd.done) begin
         instr_q <= fetch_cmd.rdata;
      end
      if (state_q == st_memory && data_cmd.done) begin
         load_q <= data_cmd.rdata;
      end
   end

   assign pc_o        = pc_q;
   assign instr_o     = instr_q;
   assign load_data_o = load_q;
   assign wb_strobe_o = (state_q == st_writeback);
   assign running_o   = (state_q != st_idle) && (state_q != st_done);
   assign finished_o  = finished_q;
   assign timeout_o   = timeout_q;

endmodule

// File: hw/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top #(
   parameter rv_pkg::word_t reset_pc_p    = 32'h0000_0000,
   parameter rv_pkg::word_t result_addr_p = 32'h0000_0100,
   parameter logic [31:0]   max_cycles_p  = 32'd2000
) (
   input  logic          clk,
   input  logic          reset,
   input  logic          run_i,
   input  rv_pkg::word_t success_code_i,
   output logic          finished_program_o,
   output logic          timeout_o,
   // instruction port
   output logic          imem_req_o,
   output rv_pkg::word_t imem_addr_o,
   input  logic          imem_gnt_i,
   input  logic          imem_rvalid_i,
   input  rv_pkg::word_t imem_rdata_i,
   // data port
   output logic          dmem_req_o,
   output rv_pkg::word_t dmem_addr_o,
   output logic          dmem_we_o,
   output logic [3:0]    dmem_be_o,
   output rv_pkg::word_t dmem_wdata_o,
   input  logic          dmem_gnt_i,
   input  logic          dmem_rvalid_i,
   input  rv_pkg::word_t dmem_rdata_i
);
   import rv_pkg::*;

   word_t     pc;
   word_t     instr;
   word_t     load_data;
   word_t     next_pc;
   word_t     rs1_data;
   word_t     rs2_data;
   word_t     rd_data;
   reg_idx_t  rs1;
   reg_idx_t  rs2;
   reg_idx_t  rd;
   logic      rd_we;
   logic      wb_strobe;
   logic      running;
   logic      expired;
   logic      end_hit;
   mem_kind_t mem_kind;

   mem_cmd_if fetch_cmd ();
   mem_cmd_if data_cmd ();

   run_fsm #(
      .reset_pc_p (reset_pc_p)
   ) u_run_fsm (
      .clk         (clk),
      .reset       (reset),
      .run_i       (run_i),
      .end_hit_i   (end_hit),
      .mem_kind_i  (mem_kind),
      .next_pc_i   (next_pc),
      .expired_i   (expired),
      .fetch_cmd   (fetch_cmd.requester),
      .data_cmd    (data_cmd.starter),
      .pc_o        (pc),
      .instr_o     (instr),
      .load_data_o (load_data),
      .wb_strobe_o (wb_strobe),
      .running_o   (running),
      .finished_o  (finished_program_o),
      .timeout_o   (timeout_o)
   );

   cycle_timer #(
      .max_cycles_p (max_cycles_p)
   ) u_cycle_timer (
      .clk       (clk),
      .reset     (reset),
      .running_i (running),
      .expired_o (expired)
   );

   execute_unit #(
      .result_addr_p (result_addr_p)
   ) u_execute_unit (
      .pc_i           (pc),
      .instr_i        (instr),
      .rs1_data_i     (rs1_data),
      .rs2_data_i     (rs2_data),
      .load_data_i    (load_data),
      .success_code_i (success_code_i),
      .wb_strobe_i    (wb_strobe),
      .rs1_o          (rs1),
      .rs2_o          (rs2),
      .rd_o           (rd),
      .rd_we_o        (rd_we),
      .rd_data_o      (rd_data),
      .mem_kind_o     (mem_kind),
      .next_pc_o      (next_pc),
      .end_hit_o      (end_hit),
      .data_cmd       (data_cmd.command)
   );

   reg_file u_reg_file (
      .clk        (clk),
      .reset      (reset),
      .rs1_i      (rs1),
      .rs2_i      (rs2),
      .rd_i       (rd),
      .we_i       (rd_we),
      .wdata_i    (rd_data),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data)
   );

   // instruction side is read only
   mem_master u_imem (
      .clk      (clk),
      .reset    (reset),
      .cmd      (fetch_cmd.engine),
      .req_o    (imem_req_o),
      .addr_o   (imem_addr_o),
      .we_o     (),
      .be_o     (),
      .wdata_o  (),
      .gnt_i    (imem_gnt_i),
      .rvalid_i (imem_rvalid_i),
      .rdata_i  (imem_rdata_i)
   );

   mem_master u_dmem (
      .clk      (clk),
      .reset    (reset),
      .cmd      (data_cmd.engine),
      .req_o    (dmem_req_o),
      .addr_o   (dmem_addr_o),
      .we_o     (dmem_we_o),
      .be_o     (dmem_be_o),
      .wdata_o  (dmem_wdata_o),
      .gnt_i    (dmem_gnt_i),
      .rvalid_i (dmem_rvalid_i),
      .rdata_i  (dmem_rdata_i)
   );

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

   localparam int xlen = 32;

   typedef logic [xlen-1:0] word_t;
   typedef logic [4:0]      reg_idx_t;

   // base opcodes of the kept subset
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_op_imm = 7'b0010011;
   localparam logic [6:0] op_op     = 7'b0110011;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;

   // funct3 for ALU ops
   localparam logic [2:0] f3_add_sub = 3'b000;
   localparam logic [2:0] f3_slt     = 3'b010;
   localparam logic [2:0] f3_xor     = 3'b100;
   localparam logic [2:0] f3_or      = 3'b110;
   localparam logic [2:0] f3_and     = 3'b111;

   // funct3 for branches and word access
   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_word = 3'b010;

   localparam logic [6:0] f7_base = 7'b0000000;
   localparam logic [6:0] f7_sub  = 7'b0100000;

   typedef enum logic [2:0] {
      st_idle,
      st_fetch,
      st_execute,
      st_memory,
      st_writeback,
      st_done
   } run_state_t;

   typedef enum logic [1:0] {
      mk_none,
      mk_load,
      mk_store
   } mem_kind_t;

endpackage

// File: tb.f
hw/rv_pkg.sv
hw/mem_cmd_if.sv
hw/run_fsm.sv
hw/cycle_timer.sv
hw/mem_master.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/rv_core_top.sv
testbench/tb_clock.sv
testbench/core_asserts.sv
testbench/tb_top.sv

// File: testbench/core_asserts.sv
`timescale 1ns/1ns

module core_asserts #(
   parameter logic [31:0] reset_pc_p = 32'h0
) (
   input logic        clk,
   input logic        reset,
   input logic        finished,
   input logic        timeout,
   input logic        imem_req,
   input logic [31:0] imem_addr,
   input logic        imem_gnt,
   input logic        imem_rvalid,
   input logic        dmem_req,
   input logic [31:0] dmem_addr,
   input logic        dmem_we,
   input logic [3:0]  dmem_be,
   input logic [31:0] dmem_wdata,
   input logic        dmem_gnt,
   input logic        dmem_rvalid
);

   logic first_fetch;
   logic imem_granted;
   logic dmem_granted;
   // number of assertion failures so far
   int   assert_fails = 0;

   // tracks the window between grant and rvalid
   always_ff @(posedge clk) begin
      if (reset) begin
         first_fetch  <= 1'b1;
         imem_granted <= 1'b0;
         dmem_granted <= 1'b0;
      end else begin
         if (imem_req) begin
            first_fetch <= 1'b0;
         end
         if (imem_req && imem_gnt) begin
            imem_granted <= 1'b1;
         end else if (imem_rvalid) begin
            imem_granted <= 1'b0;
         end
         if (dmem_req && dmem_gnt) begin
            dmem_granted <= 1'b1;
         end else if (dmem_rvalid) begin
            dmem_granted <= 1'b0;
         end
      end
   end

   reset_state: assert property (@(posedge clk) $fell(reset) |->
      !finished && !timeout && !imem_req && !dmem_req)
      else begin
         assert_fails++;
         $error("outputs not idle after reset");
      end

   first_addr: assert property (@(posedge clk) disable iff (reset)
      imem_req && first_fetch |-> imem_addr == reset_pc_p)
      else begin
         assert_fails++;
         $error("first fetch not at reset pc");
      end

   imem_hold: assert property (@(posedge clk) disable iff (reset)
      imem_req && !imem_gnt |=> imem_req && $stable(imem_addr))
      else begin
         assert_fails++;
         $error("imem request dropped or changed before grant");
      end

   dmem_hold: assert property (@(posedge clk) disable iff (reset)
      dmem_req && !dmem_gnt |=> dmem_req && $stable(dmem_addr) && $stable(dmem_we)
         && $stable(dmem_be) && $stable(dmem_wdata))
      else begin
         assert_fails++;
         $error("dmem request dropped or changed before grant");
      end

   imem_quiet: assert property (@(posedge clk) disable iff (reset)
      !(imem_granted && imem_req))
      else begin
         assert_fails++;
         $error("imem request between grant and rvalid");
      end

   dmem_quiet: assert property (@(posedge clk) disable iff (reset)
      !(dmem_granted && dmem_req))
      else begin
         assert_fails++;
         $error("dmem request between grant and rvalid");
      end

   done_holds: assert property (@(posedge clk) disable iff (reset)
      finished |=> finished)
      else begin
         assert_fails++;
         $error("finished dropped without reset");
      end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
   parameter int period_p = 40
) (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever #(period_p / 2) clk_o = ~clk_o;
   end

   // power-on reset for two cycles
   initial begin
      reset_o = 1'b1;
      repeat (2) @(posedge clk_o);
      reset_o <= 1'b0;
   end

endmodule

// File: testbench/tb_top.sv
`timescale 1ns/1ns

module tb_top;

   localparam logic [31:0] reset_pc    = 32'h0000_0000;
   localparam logic [31:0] result_addr = 32'h0000_0100;
   localparam int          max_cycles  = 2000;
   localparam int          seed        = 15;
   // retired instructions of the first run, worst cycles per instruction, margin
   localparam int          retire_count = 38;
   localparam int          worst_cpi    = 30;
   localparam int          run1_limit   = retire_count * worst_cpi + 50;
   localparam int          run2_tail    = 20;
   localparam int          watchdog_cycles = run1_limit + max_cycles + run2_tail + 100;

   logic        clk;
   logic        por_reset;
   logic        tb_reset;
   logic        run;
   logic [31:0] success_code;
   logic        finished;
   logic        timeout;
   logic        imem_req, imem_gnt, imem_rvalid;
   logic [31:0] imem_addr, imem_rdata;
   logic        dmem_req, dmem_we, dmem_gnt, dmem_rvalid;
   logic [3:0]  dmem_be;
   logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;

   logic [31:0] imem [64];
   logic [31:0] dmem [128];
   logic [31:0] last_result;
   int          result_stores;
   int          errors;
   int          cycles;
   int          i_gdly, i_rdly, d_gdly, d_rdly;
   logic        i_busy, d_busy;
   logic [31:0] i_lat, d_lat;

   tb_clock #(.period_p(40)) u_clock (.clk_o(clk), .reset_o(por_reset));

   rv_core_top #(
      .reset_pc_p    (reset_pc),
      .result_addr_p (result_addr),
      .max_cycles_p  (max_cycles)
   ) u_dut (
      .clk (clk), .reset (por_reset | tb_reset), .run_i (run),
      .success_code_i (success_code),
      .finished_program_o (finished), .timeout_o (timeout),
      .imem_req_o (imem_req), .imem_addr_o (imem_addr),
      .imem_gnt_i (imem_gnt), .imem_rvalid_i (imem_rvalid), .imem_rdata_i (imem_rdata),
      .dmem_req_o (dmem_req), .dmem_addr_o (dmem_addr), .dmem_we_o (dmem_we),
      .dmem_be_o (dmem_be), .dmem_wdata_o (dmem_wdata),
      .dmem_gnt_i (dmem_gnt), .dmem_rvalid_i (dmem_rvalid), .dmem_rdata_i (dmem_rdata)
   );

   // RV32 instruction formats
   function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic load_program();
      for (int i = 0; i < 64; i++) begin
         imem[i] = enc_i(12'd0, 5'd0, 3'b000, 5'd0, 7'b0010011);
      end
      imem[0]  = enc_i(12'd0, 5'd0, 3'b000, 5'd1, 7'b0010011);
      imem[1]  = enc_i(12'd5, 5'd0, 3'b000, 5'd2, 7'b0010011);
      // loop body at 0x08
      imem[2]  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd1);
      imem[3]  = enc_s(12'h080, 5'd1, 5'd0);
      imem[4]  = enc_i(12'h080, 5'd0, 3'b010, 5'd3, 7'b0000011);
      imem[5]  = enc_i(-12'sd1, 5'd2, 3'b000, 5'd2, 7'b0010011);
      imem[6]  = enc_b(-13'sd16, 5'd0, 5'd2, 3'b001);
      imem[7]  = enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4);
      imem[8]  = enc_r(7'h00, 5'd3, 5'd4, 3'b111, 5'd5);
      imem[9]  = enc_r(7'h00, 5'd0, 5'd5, 3'b110, 5'd6);
      imem[10] = enc_r(7'h00, 5'd3, 5'd6, 3'b100, 5'd7);
      imem[11] = enc_r(7'h00, 5'd6, 5'd7, 3'b010, 5'd8);
      // call at 0x30 skips the store at 0x34
      imem[12] = enc_j(21'd16, 5'd10);
      imem[13] = enc_s(12'h08c, 5'd1, 5'd0);
      imem[14] = enc_j(21'd0, 5'd0);
      imem[15] = enc_j(21'd0, 5'd0);
      imem[16] = {20'h12345, 5'd9, 7'b0110111};
      imem[17] = enc_s(12'h084, 5'd8, 5'd0);
      imem[18] = enc_s(12'h088, 5'd10, 5'd0);
      imem[19] = enc_s(12'h090, 5'd9, 5'd0);
      imem[20] = enc_s(12'h100, 5'd6, 5'd0);
      imem[21] = enc_j(21'd0, 5'd0);
      for (int i = 0; i < 128; i++) begin
         dmem[i] = 32'hd00d_0000 ^ (i * 4);
      end
   endtask

   task automatic check_word(logic [31:0] addr, logic [31:0] expected, string what);
      if (dmem[addr[8:2]] !== expected) begin
         $display("Fail %0t: %s at 0x%08h is 0x%08h, expected 0x%08h",
                  $time, what, addr, dmem[addr[8:2]], expected);
         errors++;
      end
   endtask

   // instruction port responder
   always @(posedge clk) begin
      if (por_reset || tb_reset) begin
         imem_gnt    <= 1'b0;
         imem_rvalid <= 1'b0;
         i_busy = 1'b0;
         i_gdly = $urandom_range(0, 3);
      end else if (i_busy) begin
         if (imem_rvalid) begin
            imem_rvalid <= 1'b0;
            i_busy = 1'b0;
            i_gdly = $urandom_range(0, 3);
         end else if (i_rdly == 0) begin
            imem_rvalid <= 1'b1;
            imem_rdata  <= imem[i_lat[7:2]];
         end else begin
            i_rdly--;
         end
      end else if (imem_req) begin
         if (imem_gnt) begin
            imem_gnt <= 1'b0;
            i_busy = 1'b1;
            i_lat  = imem_addr;
            i_rdly = $urandom_range(0, 3);
         end else if (i_gdly == 0) begin
            imem_gnt <= 1'b1;
         end else begin
            i_gdly--;
         end
      end
   end

   // data port responder that applies byte-enabled writes at the grant
   always @(posedge clk) begin
      if (por_reset || tb_reset) begin
         dmem_gnt    <= 1'b0;
         dmem_rvalid <= 1'b0;
         d_busy = 1'b0;
         d_gdly = $urandom_range(0, 3);
      end else if (d_busy) begin
         if (dmem_rvalid) begin
            dmem_rvalid <= 1'b0;
            d_busy = 1'b0;
            d_gdly = $urandom_range(0, 3);
         end else if (d_rdly == 0) begin
            dmem_rvalid <= 1'b1;
            dmem_rdata  <= dmem[d_lat[8:2]];
         end else begin
            d_rdly--;
         end
      end else if (dmem_req) begin
         if (dmem_gnt) begin
            dmem_gnt <= 1'b0;
            d_busy = 1'b1;
            d_lat  = dmem_addr;
            d_rdly = $urandom_range(0, 3);
            if (dmem_we) begin
               for (int b = 0; b < 4; b++) begin
                  if (dmem_be[b]) begin
                     dmem[dmem_addr[8:2]][b*8 +: 8] = dmem_wdata[b*8 +: 8];
                  end
               end
               if (dmem_addr == result_addr) begin
                  last_result = dmem[dmem_addr[8:2]];
                  result_stores++;
               end
            end
         end else if (d_gdly == 0) begin
            dmem_gnt <= 1'b1;
         end else begin
            d_gdly--;
         end
      end
   end

   initial begin
      int link;
      int sum;
      void'($urandom(seed));
      errors        = 0;
      result_stores = 0;
      last_result   = '0;
      tb_reset      = 1'b0;
      run           = 1'b0;
      success_code  = 32'd15;
      imem_gnt      = 1'b0;
      imem_rvalid   = 1'b0;
      imem_rdata    = '0;
      dmem_gnt      = 1'b0;
      dmem_rvalid   = 1'b0;
      dmem_rdata    = '0;
      load_program();
      sum = 0;
      for (int k = 1; k <= 5; k++) begin
         sum += k;
      end
      // jal sits at 0x30
      link = 32'h30 + 4;

      wait (!por_reset);
      @(posedge clk);
      run <= 1'b1;
      wait (finished);
      @(posedge clk);
      if (timeout) begin
         $display("Fail %0t: timeout_o set on a successful run", $time);
         errors++;
      end
      if (result_stores != 1 || last_result !== sum) begin
         $display("Fail %0t: result word 0x%08h after %0d stores, expected %0d",
                  $time, last_result, result_stores, sum);
         errors++;
      end
      check_word(32'h80, sum, "partial sum");
      check_word(32'h84, 32'd1, "slt result");
      check_word(32'h88, link, "jal link");
      check_word(32'h8c, 32'hd00d_0000 ^ 32'h8c, "skipped store");
      check_word(32'h90, 32'h1234_5000, "lui value");

      // second run never matches the success code
      run          <= 1'b0;
      success_code <= 32'd99;
      tb_reset     <= 1'b1;
      repeat (2) @(posedge clk);
      tb_reset      <= 1'b0;
      result_stores = 0;
      @(posedge clk);
      run <= 1'b1;
      cycles = 0;
      while (!finished) begin
         @(posedge clk);
         cycles++;
      end
      if (!timeout || cycles < max_cycles || cycles > max_cycles + run2_tail) begin
         $display("Fail %0t: timeout run ended after %0d cycles with timeout_o %0b",
                  $time, cycles, timeout);
         errors++;
      end
      if (result_stores != 1) begin
         $display("Fail %0t: %0d result stores in timeout run", $time, result_stores);
         errors++;
      end

      $display("closing report: %0d value errors, %0d assertion errors, 0 watchdog errors",
               errors, u_dut.u_asserts.assert_fails);
      if (errors == 0 && u_dut.u_asserts.assert_fails == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      #(watchdog_cycles * 40);
      $display("watchdog expired before both runs finished");
      $display("closing report: %0d value errors, %0d assertion errors, 1 watchdog errors",
               errors, u_dut.u_asserts.assert_fails);
      $display("TEST FAILED");
      $finish;
   end

endmodule

bind rv_core_top core_asserts #(
   .reset_pc_p (reset_pc_p)
) u_asserts (
   .clk           (clk),
   .reset         (reset),
   .finished      (finished_program_o),
   .timeout       (timeout_o),
   .imem_req      (imem_req_o),
   .imem_addr     (imem_addr_o),
   .imem_gnt      (imem_gnt_i),
   .imem_rvalid   (imem_rvalid_i),
   .dmem_req      (dmem_req_o),
   .dmem_addr     (dmem_addr_o),
   .dmem_we       (dmem_we_o),
   .dmem_be       (dmem_be_o),
   .dmem_wdata    (dmem_wdata_o),
   .dmem_gnt      (dmem_gnt_i),
   .dmem_rvalid   (dmem_rvalid_i)
);
